// ==== verilog.f ====
bioee_pkg.sv
strobe_divider.sv
control_vector.sv
adc_capture.sv
sample_fifo.sv
block_throttle.sv
bioee_daq_top.sv
bioee_daq_properties.sv
tb_bioee_checker.sv
tb_bioee_daq.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_bioee_daq -f verilog.f
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

output=$(./obj_dir/Vtb_bioee_daq)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx '=== PASS ==='; then
   exit 0
fi
exit 1

// ==== tb_bioee_daq.sv ====
`timescale 1ns/1ps

module tb_bioee_daq;

   localparam int timeout_cycles =
      (bioee_pkg::fifo_depth + 300) * bioee_pkg::adc_divide * 3;
   localparam logic [bioee_pkg::count_width-1:0] full_count =
      bioee_pkg::count_width'(bioee_pkg::fifo_depth);

   logic                               okClk;
   logic                               rst;
   logic                               pipe_in_write;
   logic [bioee_pkg::word_width-1:0]   pipe_in_data;
   logic [bioee_pkg::adc_width-1:0]    adc_data;
   logic                               pipe_out_read;
   logic                               adc_sample_tick;
   logic [bioee_pkg::word_width-1:0]   pipe_out_data;
   logic                               pipe_out_ready;
   logic [bioee_pkg::count_width-1:0]  fill_count;
   logic                               fill_level_trigger;
   logic [bioee_pkg::extbus_width-1:0] extbus_out;

   integer seed;
   int     error_count;
   int     words_checked;
   int     local_errors;
   int     errors_before;
   int     tests_run;
   int     tests_failed;
   int     strobes;

   bioee_daq_top i_bioee_daq_top (.*);

   tb_bioee_checker i_checker (.*);

   initial okClk = 1'b0;
   always #50 okClk = ~okClk;

   // One clock of stimulus, new ADC value right after each sample tick
   task automatic step(input logic wr_en, input logic rd_en, input logic rst_val);
      @(posedge okClk);
      rst <= rst_val;
      if (adc_sample_tick) begin
         adc_data <= bioee_pkg::adc_width'($random(seed));
      end
      pipe_in_write <= wr_en && (($random(seed) & 7) == 0);
      pipe_in_data  <= $random(seed);
      pipe_out_read <= rd_en && (($random(seed) & 1) == 1);
   endtask

   task automatic flag_error(input string msg);
      $display("MISMATCH at %0t: %s", $time, msg);
      local_errors++;
   endtask

   task automatic close_test(input string name);
      int errs;
      errs = error_count + local_errors +
             i_bioee_daq_top.i_block_throttle.i_throttle_props.fail_count - errors_before;
      tests_run++;
      if (errs != 0) begin
         tests_failed++;
      end
      $display("test %-16s %s (%0d errors)", name, (errs == 0) ? "ok" : "FAILED", errs);
      errors_before = errors_before + errs;
   endtask

   initial begin
      seed = 32'h98dbf5c7;
      rst = 1'b1;
      pipe_in_write = 1'b0;
      pipe_in_data = '0;
      adc_data = '0;
      pipe_out_read = 1'b0;
      local_errors = 0;
      errors_before = 0;
      tests_run = 0;
      tests_failed = 0;
      repeat (8) step(1'b0, 1'b0, 1'b1);

      // Light traffic across several vector strobes
      repeat (bioee_pkg::vector_divide * 6) step(1'b1, 1'b1, 1'b0);
      close_test("vector_transfer");

      // No reads until full, then 50 more samples that must be lost
      while (fill_count != full_count) step(1'b1, 1'b0, 1'b0);
      strobes = 0;
      while (strobes < 50) begin
         step(1'b1, 1'b0, 1'b0);
         if (adc_sample_tick) begin
            strobes++;
         end
      end
      if (fill_count != full_count) begin
         flag_error($sformatf("fill_count %0d after overflow", fill_count));
      end
      close_test("overflow_fill");

      while (fill_count != '0) step(1'b1, 1'b1, 1'b0);
      close_test("random_drain");

      // Reset with a partly filled buffer and a loaded vector
      repeat (500) step(1'b1, 1'b0, 1'b0);
      repeat (8) step(1'b0, 1'b0, 1'b1);
      if (fill_count != '0 || pipe_out_ready || fill_level_trigger || extbus_out != '0) begin
         flag_error("outputs not cleared by mid-run reset");
      end
      repeat (300) step(1'b1, 1'b1, 1'b0);
      close_test("mid_run_reset");

      $display("tests %0d, passed %0d, failed %0d, errors %0d, words checked %0d",
               tests_run, tests_run - tests_failed, tests_failed, errors_before,
               words_checked);
      if (tests_failed == 0 && errors_before == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // Watchdog, three times the longest expected run
   initial begin
      repeat (timeout_cycles) @(posedge okClk);
      $display("watchdog expired after %0d cycles, a test never finished", timeout_cycles);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

// ==== tb_bioee_checker.sv ====
`timescale 1ns/1ps

module tb_bioee_checker (
   input  logic                               okClk,
   input  logic                               rst,
   input  logic                               pipe_in_write,
   input  logic [bioee_pkg::word_width-1:0]   pipe_in_data,
   input  logic [bioee_pkg::adc_width-1:0]    adc_data,
   input  logic                               pipe_out_read,
   input  logic                               adc_sample_tick,
   input  logic [bioee_pkg::word_width-1:0]   pipe_out_data,
   input  logic                               pipe_out_ready,
   input  logic [bioee_pkg::count_width-1:0]  fill_count,
   input  logic                               fill_level_trigger,
   input  logic [bioee_pkg::extbus_width-1:0] extbus_out,
   output int                                 error_count,
   output int                                 words_checked
);

   logic                             model_valid;
   int                               edges;
   logic [bioee_pkg::word_width-1:0] pend_m;
   logic [bioee_pkg::word_width-1:0] vec_m;
   logic                             write_m;
   logic [bioee_pkg::word_width-1:0] word_m;
   logic                             ready_m;
   logic                             trig_m;
   logic [bioee_pkg::word_width-1:0] words [$];

   // Upper half zero, ADC bits reversed into 15..2, bit 1 clear, trigger in bit 0
   function automatic logic [31:0] pack_word(input logic [13:0] adc, input logic trig);
      logic [13:0] rev;
      rev = {<<{adc}};
      return {16'h0000, rev, 1'b0, trig};
   endfunction

   task automatic mismatch(input string msg);
      $display("MISMATCH at %0t: %s", $time, msg);
      error_count++;
   endtask

   initial begin
      model_valid = 1'b0;
      error_count = 0;
      words_checked = 0;
   end

   // ========================================================================
   // Compare at the falling edge, then advance the model one clock
   // ========================================================================

   always @(negedge okClk) begin
      logic stick;
      logic vtick;
      logic avail;
      logic pushed;
      logic popped;
      stick = (edges > 0) && (edges % bioee_pkg::adc_divide == 0);
      vtick = (edges > 0) && (edges % bioee_pkg::vector_divide == 0);
      if (model_valid) begin
         if (adc_sample_tick !== stick)
            mismatch($sformatf("sample tick %b, expected %b", adc_sample_tick, stick));
         if (extbus_out !== vec_m[bioee_pkg::extbus_width-1:0])
            mismatch($sformatf("extbus_out %h, expected %h", extbus_out,
                               vec_m[bioee_pkg::extbus_width-1:0]));
         if (fill_count !== bioee_pkg::count_width'(words.size()))
            mismatch($sformatf("fill_count %0d, expected %0d", fill_count, words.size()));
         if (pipe_out_ready !== ready_m)
            mismatch($sformatf("pipe_out_ready %b, expected %b", pipe_out_ready, ready_m));
         if (fill_level_trigger !== trig_m)
            mismatch($sformatf("fill_level_trigger %b, expected %b", fill_level_trigger, trig_m));
         if (pipe_out_read && words.size() > 0) begin
            words_checked++;
            if (pipe_out_data !== words[0])
               mismatch($sformatf("pipe_out_data %h, expected %h", pipe_out_data, words[0]));
         end
      end
      if (rst) begin
         model_valid = 1'b1;
         edges = 0;
         pend_m = '0;
         vec_m = '0;
         write_m = 1'b0;
         ready_m = 1'b0;
         trig_m = 1'b0;
         words.delete();
      end else if (model_valid) begin
         avail = words.size() >= bioee_pkg::block_size;
         trig_m = avail && !ready_m;
         ready_m = avail;
         // Full buffer drops the word even when a read lands on the same edge
         popped = pipe_out_read && words.size() > 0;
         pushed = write_m && words.size() < bioee_pkg::fifo_depth;
         if (popped) void'(words.pop_front());
         if (pushed) words.push_back(word_m);
         write_m = stick;
         if (stick) word_m = pack_word(adc_data, vec_m[bioee_pkg::daq_trigger_bit]);
         if (vtick) vec_m = pend_m;
         if (pipe_in_write) pend_m = pipe_in_data;
         edges++;
      end
   end

endmodule

// ==== bioee_daq_properties.sv ====
`timescale 1ns/1ps

module bioee_daq_properties (
   input logic                              okClk,
   input logic                              rst,
   input logic [bioee_pkg::count_width-1:0] count,
   input logic                              pipe_out_ready,
   input logic                              fill_level_trigger
);

   localparam logic [bioee_pkg::count_width-1:0] block_count =
      bioee_pkg::count_width'(bioee_pkg::block_size);

   int fail_count = 0;

   // Ready is last cycle's comparison of count against one block
   ready_registered: assert property (@(posedge okClk) disable iff (rst)
      !$past(rst) |-> (pipe_out_ready == ($past(count) >= block_count)))
      else begin
         fail_count++;
         $error("pipe_out_ready does not follow the registered count comparison");
      end

   trigger_one_cycle: assert property (@(posedge okClk) disable iff (rst)
      fill_level_trigger |=> !fill_level_trigger)
      else begin
         fail_count++;
         $error("fill_level_trigger held for more than one cycle");
      end

   // Pulse only after count went from below one block to at least one block
   trigger_on_crossing: assert property (@(posedge okClk) disable iff (rst)
      (fill_level_trigger && !$past(rst)) |->
         ($past(count) >= block_count && $past(count, 2) < block_count))
      else begin
         fail_count++;
         $error("fill_level_trigger without an upward crossing of the block size");
      end

endmodule

bind block_throttle bioee_daq_properties i_throttle_props (
   .okClk              (okClk),
   .rst                (rst),
   .count              (count),
   .pipe_out_ready     (pipe_out_ready),
   .fill_level_trigger (fill_level_trigger)
);

// ==== bioee_daq_top.sv ====
`timescale 1ns/1ps

module bioee_daq_top (
   input  logic                               okClk,
   input  logic                               rst,

   // Host pipe-in
   input  logic                               pipe_in_write,
   input  logic [bioee_pkg::word_width-1:0]   pipe_in_data,

   // ADC
   input  logic [bioee_pkg::adc_width-1:0]    adc_data,
   output logic                               adc_sample_tick,

   // Host pipe-out
   input  logic                               pipe_out_read,
   output logic [bioee_pkg::word_width-1:0]   pipe_out_data,
   output logic                               pipe_out_ready,
   output logic [bioee_pkg::count_width-1:0]  fill_count,
   output logic                               fill_level_trigger,

   // External bus
   output logic [bioee_pkg::extbus_width-1:0] extbus_out
);

   logic                              sample_tick;
   logic                              vector_tick;
   logic [bioee_pkg::word_width-1:0]  vector_out;
   logic                              sample_write;
   logic [bioee_pkg::word_width-1:0]  sample_word;
   logic [bioee_pkg::count_width-1:0] count;

   // ========================================================================
   // Strobes
   // ========================================================================

   strobe_divider #(
      .DIVIDE (bioee_pkg::adc_divide)
   ) sample_divider (
      .okClk (okClk),
      .rst   (rst),
      .tick  (sample_tick)
   );

   strobe_divider #(
      .DIVIDE (bioee_pkg::vector_divide)
   ) vector_divider (
      .okClk (okClk),
      .rst   (rst),
      .tick  (vector_tick)
   );

   // Stands in for the ADC conversion clock
   assign adc_sample_tick = sample_tick;

   // ========================================================================
   // Control vector
   // ========================================================================

   control_vector i_control_vector (
      .okClk         (okClk),
      .rst           (rst),
      .vector_tick   (vector_tick),
      .pipe_in_write (pipe_in_write),
      .pipe_in_data  (pipe_in_data),
      .vector_out    (vector_out)
   );

   assign extbus_out = vector_out[bioee_pkg::extbus_width-1:0];

   // ========================================================================
   // Acquisition path
   // ========================================================================

   adc_capture i_adc_capture (
      .okClk        (okClk),
      .rst          (rst),
      .sample_tick  (sample_tick),
      .adc_data     (adc_data),
      .daq_trigger  (vector_out[bioee_pkg::daq_trigger_bit]),
      .sample_write (sample_write),
      .sample_word  (sample_word)
   );

   // No back-pressure toward the ADC, a full buffer loses samples
   sample_fifo #(
      .DEPTH (bioee_pkg::fifo_depth)
   ) i_sample_fifo (
      .okClk      (okClk),
      .rst        (rst),
      .write      (sample_write),
      .write_data (sample_word),
      .read       (pipe_out_read),
      .read_data  (pipe_out_data),
      .count      (count),
      .full       (),
      .empty      ()
   );

   block_throttle i_block_throttle (
      .okClk              (okClk),
      .rst                (rst),
      .count              (count),
      .pipe_out_ready     (pipe_out_ready),
      .fill_level_trigger (fill_level_trigger),
      .fill_count         (fill_count)
   );

endmodule

// ==== block_throttle.sv ====
`timescale 1ns/1ps

module block_throttle (
   input  logic                              okClk,
   input  logic                              rst,
   input  logic [bioee_pkg::count_width-1:0] count,
   output logic                              pipe_out_ready,
   output logic                              fill_level_trigger,
   output logic [bioee_pkg::count_width-1:0] fill_count
);

   localparam logic [bioee_pkg::count_width-1:0] block_count =
      bioee_pkg::count_width'(bioee_pkg::block_size);

   // At least one full block is buffered
   logic block_avail;

   assign block_avail = (count >= block_count);

   // ========================================================================
   // Ready level and crossing pulse
   // ========================================================================

   // pipe_out_ready doubles as the previous comparison result, so the
   // crossing test sees block_avail now against block_avail last cycle
   always_ff @(posedge okClk) begin
      if (rst) begin
         pipe_out_ready     <= 1'b0;
         fill_level_trigger <= 1'b0;
      end else begin
         pipe_out_ready     <= block_avail;
         fill_level_trigger <= block_avail && !pipe_out_ready;
      end
   end

   // Fill level reported to the host as is
   assign fill_count = count;

   // Trigger rises together with ready on an upward crossing
   // and stays low while the level holds or falls

endmodule

// ==== sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo #(
   parameter int DEPTH = bioee_pkg::fifo_depth
) (
   input  logic                              okClk,
   input  logic                              rst,
   input  logic                              write,
   input  logic [bioee_pkg::word_width-1:0]  write_data,
   input  logic                              read,
   output logic [bioee_pkg::word_width-1:0]  read_data,
   output logic [bioee_pkg::count_width-1:0] count,
   output logic                              full,
   output logic                              empty
);

   localparam int addr_width = $clog2(DEPTH);
   localparam logic [bioee_pkg::count_width-1:0] full_count =
      bioee_pkg::count_width'(DEPTH);

   // ========================================================================
   // Storage and pointers
   // ========================================================================

   logic [bioee_pkg::word_width-1:0] mem [DEPTH];

   logic [addr_width-1:0] wr_ptr;
   logic [addr_width-1:0] rd_ptr;

   // Qualified requests
   logic do_write;
   logic do_read;

   assign full  = (count == full_count);
   assign empty = (count == '0);

   // Write while full drops the word, read while empty does nothing
   assign do_write = write && !full;
   assign do_read  = read && !empty;

   always_ff @(posedge okClk) begin
      if (do_write) begin
         mem[wr_ptr] <= write_data;
      end
   end

   // Pointers wrap on their own since DEPTH is a power of two
   always_ff @(posedge okClk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // ========================================================================
   // Occupancy
   // ========================================================================

   // Simultaneous push and pop leaves the count unchanged
   always_ff @(posedge okClk) begin
      if (rst) begin
         count <= '0;
      end else begin
         case ({do_write, do_read})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Show-ahead head word
   assign read_data = mem[rd_ptr];

   // Contents of read_data are only meaningful while not empty;
   // the host samples it together with its read strobe

endmodule

// ==== adc_capture.sv ====
`timescale 1ns/1ps

module adc_capture (
   input  logic                             okClk,
   input  logic                             rst,
   input  logic                             sample_tick,
   input  logic [bioee_pkg::adc_width-1:0]  adc_data,
   input  logic                             daq_trigger,
   output logic                             sample_write,
   output logic [bioee_pkg::word_width-1:0] sample_word
);

   // Top bit of the reversed ADC field in the packed word
   localparam int field_top = bioee_pkg::adc_width + 1;

   logic [bioee_pkg::adc_width-1:0] adc_q;
   logic                            trigger_q;

   // ADC bus and trigger held from one sample strobe to the next
   always_ff @(posedge okClk) begin
      if (sample_tick) begin
         adc_q     <= adc_data;
         trigger_q <= daq_trigger;
      end
   end

   // Write strobe for the FIFO, one cycle after the sample strobe
   always_ff @(posedge okClk) begin
      if (rst) begin
         sample_write <= 1'b0;
      end else begin
         sample_write <= sample_tick;
      end
   end

   // ========================================================================
   // Word packing
   // ========================================================================

   // ADC bit 0 lands on word bit 15 and bit 13 on word bit 2,
   // bit 1 stays clear, trigger in bit 0, upper half zero
   always_comb begin
      sample_word = '0;
      for (int i = 0; i < bioee_pkg::adc_width; i++) begin
         sample_word[field_top - i] = adc_q[i];
      end
      sample_word[0] = trigger_q;
   end

endmodule

// ==== control_vector.sv ====
`timescale 1ns/1ps

module control_vector (
   input  logic                             okClk,
   input  logic                             rst,
   input  logic                             vector_tick,
   input  logic                             pipe_in_write,
   input  logic [bioee_pkg::word_width-1:0] pipe_in_data,
   output logic [bioee_pkg::word_width-1:0] vector_out
);

   // ========================================================================
   // Pending vector
   // ========================================================================

   // Last host word since the previous strobe
   logic [bioee_pkg::word_width-1:0] pending;

   // Each pipe-in write replaces the pending word, so only the
   // most recent write before a strobe ever reaches the bus
   always_ff @(posedge okClk) begin
      if (rst) begin
         pending <= '0;
      end else if (pipe_in_write) begin
         pending <= pipe_in_data;
      end
   end

   // ========================================================================
   // Presented vector
   // ========================================================================

   // Output only moves on the vector strobe. A write on the same edge
   // as the strobe waits for the next one
   always_ff @(posedge okClk) begin
      if (rst) begin
         vector_out <= '0;
      end else if (vector_tick) begin
         vector_out <= pending;
      end
   end

   // Downstream the low bits drive the external bus and one bit
   // acts as the DAQ trigger packed with each sample

endmodule

// ==== strobe_divider.sv ====
`timescale 1ns/1ps

module strobe_divider #(
   parameter int DIVIDE = 24
) (
   input  logic okClk,
   input  logic rst,
   output logic tick
);

   localparam int cnt_width = (DIVIDE > 1) ? $clog2(DIVIDE) : 1;
   localparam logic [cnt_width-1:0] last_count = cnt_width'(DIVIDE - 1);

   logic [cnt_width-1:0] count;

   // Free-running count 0 .. DIVIDE-1, tick registered at the wrap
   always_ff @(posedge okClk) begin
      if (rst) begin
         count <= '0;
         tick  <= 1'b0;
      end else begin
         if (count == last_count) begin
            count <= '0;
            tick  <= 1'b1;
         end else begin
            count <= count + 1'b1;
            tick  <= 1'b0;
         end
      end
   end

   // First tick lands DIVIDE cycles after reset release,
   // then one tick every DIVIDE cycles

endmodule

// ==== bioee_pkg.sv ====
package bioee_pkg;

   // ========================================================================
   // Host pipe and sensor widths
   // ========================================================================

   // Host pipe word
   localparam int word_width = 32;

   // ADC sample bus
   localparam int adc_width = 14;

   // External bus fed from the low bits of the control vector
   localparam int extbus_width = 15;

   // ========================================================================
   // Strobe ratios in okClk cycles
   // ========================================================================

   localparam int adc_divide = 24;
   localparam int vector_divide = 250;

   // ========================================================================
   // Sample buffer and pipe-out throttle
   // ========================================================================

   // Depth must stay a power of two
   localparam int fifo_depth = 1024;

   // Holds 0 up to fifo_depth inclusive
   localparam int count_width = 11;

   // 512 bytes per pipe-out block, 4 bytes per word
   localparam int block_size = 128;

   // Control vector bit packed into bit 0 of each sample word
   localparam int daq_trigger_bit = 15;

endpackage
